// ==== hdl/fetch_pkg.sv ====
/*
 * fetch prediction package
 * widths, reset values, opcodes and the structs passed between the
 * instruction scanner, the predictors and the fetch stage top
 */
`default_nettype none

package fetch_pkg;

  // ------------------------------
  // sizes and reset values
  // ------------------------------
  localparam int VLEN           = 32;
  localparam int BHT_ENTRIES    = 16;
  localparam int RAS_DEPTH      = 4;
  localparam int DECODE_CREDITS = 4;

  // widths derived from the sizes above
  localparam int BHT_IDX_W = $clog2(BHT_ENTRIES);
  localparam int RAS_CNT_W = $clog2(RAS_DEPTH + 1);
  localparam int CREDIT_W  = $clog2(DECODE_CREDITS + 1);

  typedef logic [VLEN-1:0]      vaddr_t;
  typedef logic [31:0]          instr_t;
  typedef logic [BHT_IDX_W-1:0] bht_idx_t;
  typedef logic [1:0]           bht_cnt_t;
  typedef logic [RAS_CNT_W-1:0] ras_cnt_t;
  typedef logic [CREDIT_W-1:0]  credit_cnt_t;

  localparam vaddr_t   BOOT_ADDR   = 32'h0000_1000;
  // counters start out weakly not-taken
  localparam bht_cnt_t BHT_WEAK_NT = 2'b01;

  // ------------------------------
  // opcodes seen by the scanner
  // ------------------------------
  localparam logic [6:0] OPCODE_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPCODE_JALR   = 7'b110_0111;
  localparam logic [6:0] OPCODE_JAL    = 7'b110_1111;
  // compressed quadrants and funct3 values
  localparam logic [1:0] OPCODE_C1          = 2'b01;
  localparam logic [1:0] OPCODE_C2          = 2'b10;
  localparam logic [2:0] OPCODE_C1_JAL      = 3'b001;
  localparam logic [2:0] OPCODE_C1_J        = 3'b101;
  localparam logic [2:0] OPCODE_C1_BEQZ     = 3'b110;
  localparam logic [2:0] OPCODE_C1_BNEZ     = 3'b111;
  localparam logic [2:0] OPCODE_C2_JALR_ADD = 3'b100;

  // ------------------------------
  // structs
  // ------------------------------
  // scanner result for one fetched instruction
  typedef struct packed {
    logic   rvi_return;
    logic   rvi_call;
    logic   rvi_branch;
    logic   rvi_jalr;
    logic   rvi_jump;
    vaddr_t rvi_imm;
    logic   rvc_branch;
    logic   rvc_jump;
    logic   rvc_jr;
    logic   rvc_return;
    logic   rvc_jalr;
    logic   rvc_call;
    vaddr_t rvc_imm;
    logic   is_compressed;
  } scan_t;

  // one entry handed to decode
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    instr_t instr;
    logic   is_compressed;
    logic   predict_taken;
    vaddr_t predict_target;
  } fetch_entry_t;

  // resolution of a control-flow instruction from the back end
  typedef struct packed {
    logic   valid;
    logic   is_branch;
    vaddr_t pc;
    logic   taken;
    logic   mispredict;
    vaddr_t target;
  } resolve_t;

  // counter update towards the branch history table
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    logic   taken;
  } bht_update_t;

endpackage

`default_nettype wire

// ==== hdl/instr_scan.sv ====
/*
 * instruction scanner
 * classifies one aligned instruction as branch, jump, call or return
 * and extracts its sign-extended immediate
 */
`default_nettype none

module instr_scan
  import fetch_pkg::*;
(
  input  instr_t instr_i,
  output scan_t  scan_o
);

  // ------------------------------
  // immediate builders
  // ------------------------------
  // B-type offset of a conditional branch
  function automatic vaddr_t b_imm(input instr_t instr);
    return {{(VLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  // J-type offset of a jal
  function automatic vaddr_t j_imm(input instr_t instr);
    return {{(VLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

  // the CB offset of c.beqz and c.bnez holds 9 bits with the sign taken from bit 12
  function automatic vaddr_t cb_imm(input instr_t instr);
    return {{(VLEN-8){instr[12]}}, instr[6:5], instr[2], instr[11:10],
            instr[4:3], 1'b0};
  endfunction

  // the CJ offset of c.j and c.jal holds 12 bits with the sign taken from bit 12
  function automatic vaddr_t cj_imm(input instr_t instr);
    return {{(VLEN-11){instr[12]}}, instr[8], instr[10:9], instr[6], instr[7],
            instr[2], instr[11], instr[5:3], 1'b0};
  endfunction

  logic is_rvc;
  logic is_xret;
  logic rvi_jalr;
  logic rvi_jump;
  logic rvc_jal;
  logic rvc_j;
  logic is_jal_r;
  logic rvc_jr;
  logic rvc_jalr;

  // anything whose low two bits are not 11 is a 16-bit instruction
  assign is_rvc = (instr_i[1:0] != 2'b11);

  // mret and sret differ only in bit 29 while bits 31:30 stay clear
  assign is_xret = (instr_i[31:30] == 2'b00) && (instr_i[28:0] == 29'h1020_0073);

  // ------------------------------
  // 32-bit control flow
  // ------------------------------
  assign rvi_jalr = (instr_i[6:0] == OPCODE_JALR);
  // an xret is treated as a jump to itself
  assign rvi_jump = (instr_i[6:0] == OPCODE_JAL) || is_xret;

  // a return reads x1 or x5 and does not link to the same register
  assign scan_o.rvi_return = rvi_jalr && ((instr_i[19:15] == 5'd1) || (instr_i[19:15] == 5'd5))
                             && (instr_i[19:15] != instr_i[11:7]);
  // a call links to x1 or x5
  assign scan_o.rvi_call   = (rvi_jalr || rvi_jump)
                             && ((instr_i[11:7] == 5'd1) || (instr_i[11:7] == 5'd5));
  assign scan_o.rvi_branch = (instr_i[6:0] == OPCODE_BRANCH);
  assign scan_o.rvi_jalr   = rvi_jalr;
  assign scan_o.rvi_jump   = rvi_jump;
  // bit 3 separates jal from branch; a jalr has no static target
  assign scan_o.rvi_imm    = is_xret ? '0 : (instr_i[3] ? j_imm(instr_i) : b_imm(instr_i));

  // ------------------------------
  // compressed control flow
  // ------------------------------
  // on RV32 this encoding is c.jal, which links to x1
  assign rvc_jal = is_rvc && (instr_i[1:0] == OPCODE_C1) && (instr_i[15:13] == OPCODE_C1_JAL);
  assign rvc_j   = is_rvc && (instr_i[1:0] == OPCODE_C1) && (instr_i[15:13] == OPCODE_C1_J);

  // c.jr and c.jalr share funct3 and have rs2 = x0
  assign is_jal_r = is_rvc && (instr_i[1:0] == OPCODE_C2)
                    && (instr_i[15:13] == OPCODE_C2_JALR_ADD) && (instr_i[6:2] == 5'd0);
  assign rvc_jr   = is_jal_r && !instr_i[12];
  assign rvc_jalr = is_jal_r && instr_i[12];

  assign scan_o.rvc_branch = is_rvc && (instr_i[1:0] == OPCODE_C1)
                             && ((instr_i[15:13] == OPCODE_C1_BEQZ)
                                 || (instr_i[15:13] == OPCODE_C1_BNEZ));
  assign scan_o.rvc_jump   = rvc_j || rvc_jal;
  assign scan_o.rvc_jr     = rvc_jr;
  assign scan_o.rvc_jalr   = rvc_jalr;
  assign scan_o.rvc_call   = rvc_jalr || rvc_jal;
  // c.jr through a link register is a return
  assign scan_o.rvc_return = rvc_jr && ((instr_i[11:7] == 5'd1) || (instr_i[11:7] == 5'd5));
  // funct3 bit 14 is set for the branches and clear for the jumps
  assign scan_o.rvc_imm    = instr_i[14] ? cb_imm(instr_i) : cj_imm(instr_i);

  assign scan_o.is_compressed = is_rvc;

endmodule

`default_nettype wire

// ==== hdl/bht.sv ====
/*
 * branch history table
 * 2-bit saturating counters read by fetch address, trained by resolves
 */
`default_nettype none

module bht
  import fetch_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  vaddr_t      pc_i,
  output logic        taken_o,
  input  bht_update_t update_i
);

  bht_cnt_t cnt_q [BHT_ENTRIES];
  bht_idx_t rd_idx;
  bht_idx_t wr_idx;

  // bit 0 is always zero for aligned instructions, so indexing starts at bit 1
  assign rd_idx = pc_i[BHT_IDX_W:1];
  assign wr_idx = update_i.pc[BHT_IDX_W:1];

  // the upper counter bit is the prediction
  assign taken_o = cnt_q[rd_idx][1];

  // ------------------------------
  // counter training
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        cnt_q[i] <= BHT_WEAK_NT;
      end
    end else if (update_i.valid) begin
      // count up on taken and down on not-taken, holding at both ends
      if (update_i.taken) begin
        if (cnt_q[wr_idx] != 2'b11) begin
          cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
        end
      end else begin
        if (cnt_q[wr_idx] != 2'b00) begin
          cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ras.sv ====
/*
 * return address stack
 * top entry sits at index 0, a push onto a full stack drops the oldest
 */
`default_nettype none

module ras
  import fetch_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   push_i,
  input  logic   pop_i,
  input  vaddr_t data_i,
  output vaddr_t top_o,
  output logic   empty_o
);

  vaddr_t   stack_q [RAS_DEPTH];
  ras_cnt_t count_q;

  assign top_o   = stack_q[0];
  assign empty_o = (count_q == '0);

  // ------------------------------
  // entry storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (push_i && pop_i) begin
      // pop then push only swaps the top
      stack_q[0] <= data_i;
    end else if (push_i) begin
      // everything moves one deeper and the last slot falls off
      for (int i = RAS_DEPTH - 1; i > 0; i--) begin
        stack_q[i] <= stack_q[i-1];
      end
      stack_q[0] <= data_i;
    end else if (pop_i) begin
      for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        stack_q[i] <= stack_q[i+1];
      end
    end
  end

  // occupancy, saturating at the depth on overflow
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (push_i && !pop_i) begin
      if (count_q != ras_cnt_t'(RAS_DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop_i && !push_i) begin
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end else if (push_i && pop_i && (count_q == '0)) begin
      // a replace on an empty stack still leaves one valid entry
      count_q <= ras_cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/frontend.sv ====
/*
 * fetch stage top
 * program counter, decode credits and next-pc prediction from the
 * scanner, the branch history table and the return address stack
 */
`default_nettype none

module frontend
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  output vaddr_t       fetch_addr_o,
  input  instr_t       fetch_instr_i,
  output fetch_entry_t entry_o,
  input  logic         credit_i,
  input  resolve_t     resolve_i
);

  vaddr_t      pc_q;
  credit_cnt_t credit_q;
  logic        fetch_en_q;

  scan_t       scan;
  bht_update_t bht_update;
  logic        bht_taken;
  vaddr_t      ras_top;
  logic        ras_empty;

  logic        redirect;
  logic        issue;
  logic        is_branch;
  logic        is_jump;
  logic        is_call;
  logic        is_return;
  logic        branch_taken;
  logic        return_taken;
  logic        predict_taken;
  vaddr_t      imm;
  vaddr_t      seq_pc;
  vaddr_t      predict_target;

  // ------------------------------
  // predictors
  // ------------------------------
  instr_scan i_instr_scan (
    .instr_i (fetch_instr_i),
    .scan_o  (scan)
  );

  // only conditional branches train the counters
  assign bht_update.valid = resolve_i.valid && resolve_i.is_branch;
  assign bht_update.pc    = resolve_i.pc;
  assign bht_update.taken = resolve_i.taken;

  bht i_bht (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .pc_i     (pc_q),
    .taken_o  (bht_taken),
    .update_i (bht_update)
  );

  ras i_ras (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (issue && is_call),
    .pop_i   (issue && return_taken),
    .data_i  (seq_pc),
    .top_o   (ras_top),
    .empty_o (ras_empty)
  );

  // ------------------------------
  // prediction
  // ------------------------------
  assign is_branch = scan.rvi_branch || scan.rvc_branch;
  assign is_jump   = scan.rvi_jump || scan.rvc_jump;
  assign is_call   = scan.rvi_call || scan.rvc_call;
  assign is_return = scan.rvi_return || scan.rvc_return;

  assign imm    = scan.is_compressed ? scan.rvc_imm : scan.rvi_imm;
  assign seq_pc = pc_q + (scan.is_compressed ? vaddr_t'(2) : vaddr_t'(4));

  assign branch_taken = is_branch && bht_taken;
  // with nothing on the stack a return falls through
  assign return_taken = is_return && !ras_empty;
  // other register jumps have no target source and stay not-taken
  assign predict_taken = branch_taken || is_jump || return_taken;

  always_comb begin
    if (return_taken) begin
      predict_target = ras_top;
    end else if (branch_taken || is_jump) begin
      predict_target = pc_q + imm;
    end else begin
      predict_target = seq_pc;
    end
  end

  // ------------------------------
  // issue and flow control
  // ------------------------------
  assign redirect = resolve_i.valid && resolve_i.mispredict;
  // a redirect squashes the entry fetched in the same cycle
  assign issue    = fetch_en_q && (credit_q != '0) && !redirect;

  assign fetch_addr_o = pc_q;

  assign entry_o.valid          = issue;
  assign entry_o.pc             = pc_q;
  assign entry_o.instr          = fetch_instr_i;
  assign entry_o.is_compressed  = scan.is_compressed;
  assign entry_o.predict_taken  = predict_taken;
  assign entry_o.predict_target = predict_target;

  // fetch starts the cycle after reset is released
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else if (redirect) begin
      pc_q <= resolve_i.target;
    end else if (issue) begin
      pc_q <= predict_target;
    end
  end

  // an issue and a returned credit in one cycle cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= credit_cnt_t'(DECODE_CREDITS);
    end else if (issue && !credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (credit_i && !issue) begin
      if (credit_q != credit_cnt_t'(DECODE_CREDITS)) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_frontend.sv ====
/*
 * testbench for the fetch stage
 * program image, reference predictor model and checks on every entry
 */
`default_nettype none

module tb_frontend
  import fetch_pkg::*;
();

  // the longest section runs a few hundred cycles at half the credit rate
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int DRIVE_DELAY    = 2;
  localparam instr_t NOP_INSTR  = 32'h0000_0013;
  localparam instr_t MRET_INSTR = 32'h3020_0073;

  // what the model does with an instruction at a given address
  localparam logic [2:0] K_SEQ    = 3'd0;
  localparam logic [2:0] K_BRANCH = 3'd1;
  localparam logic [2:0] K_JUMP   = 3'd2;
  localparam logic [2:0] K_CALL   = 3'd3;
  localparam logic [2:0] K_RET    = 3'd4;
  localparam logic [2:0] K_IND    = 3'd5;

  typedef struct packed {
    instr_t     instr;
    logic [2:0] kind;
    vaddr_t     imm;
  } image_t;

  logic         clk_i;
  logic         rst_n_i;
  vaddr_t       fetch_addr_o;
  instr_t       fetch_instr_i;
  fetch_entry_t entry_o;
  logic         credit_i;
  resolve_t     resolve_i;

  image_t   image [vaddr_t];
  vaddr_t   model_pc;
  bht_cnt_t cnt_m [BHT_ENTRIES];
  vaddr_t   ras_m [$];
  int       outstanding;
  int       issued;
  int       errors;
  int       cycles;
  logic [31:0] rng;

  frontend i_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_addr_o  (fetch_addr_o),
    .fetch_instr_i (fetch_instr_i),
    .entry_o       (entry_o),
    .credit_i      (credit_i),
    .resolve_i     (resolve_i)
  );

  always #20 clk_i = ~clk_i;

  // instruction port answers in the same cycle, holes read as nop
  always_comb begin
    fetch_instr_i = NOP_INSTR;
    if (image.exists(fetch_addr_o)) begin
      fetch_instr_i = image[fetch_addr_o].instr;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d errors", cycles, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic image_t read_image(input vaddr_t addr);
    image_t e;
    if (image.exists(addr)) begin
      e = image[addr];
    end else begin
      e = '{NOP_INSTR, K_SEQ, '0};
    end
    return e;
  endfunction

  task automatic put(input vaddr_t addr, input instr_t instr, input logic [2:0] kind,
                     input vaddr_t imm);
    image[addr] = '{instr, kind, imm};
  endtask

  task automatic count_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    errors++;
    $display("mismatch %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic count_failure(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  // hand-assembled sections, each one parks on an mret that jumps to itself
  task automatic load_program();
    // sequential flow, calls, returns and jumps
    put(32'h1000, NOP_INSTR,    K_SEQ,  0);
    put(32'h1004, 32'h0000_0001, K_SEQ,  0);
    put(32'h1006, 32'h0000_0001, K_SEQ,  0);
    put(32'h1008, NOP_INSTR,    K_SEQ,  0);
    put(32'h100C, 32'h0140_00EF, K_CALL, 20);
    put(32'h1010, 32'h0000_2821, K_CALL, 24);
    put(32'h1012, 32'h0000_8082, K_RET,  0);
    put(32'h1014, 32'h0003_0067, K_IND,  0);
    put(32'h1018, 32'h0000_A809, K_JUMP, 18);
    put(32'h1020, 32'h0000_8067, K_RET,  0);
    put(32'h1028, 32'h0000_8082, K_RET,  0);
    put(32'h102A, 32'h0000_0001, K_SEQ,  0);
    put(32'h102C, 32'h0140_006F, K_JUMP, 20);
    put(32'h1040, MRET_INSTR,   K_JUMP, 0);
    // beq x5, x6, +12 with a halt on each path
    put(32'h1100, 32'h0062_8663, K_BRANCH, 12);
    put(32'h1104, MRET_INSTR,   K_JUMP, 0);
    put(32'h110C, MRET_INSTR,   K_JUMP, 0);
    // c.beqz x8, +12 on its own counter
    put(32'h1210, 32'h0000_C411, K_BRANCH, 12);
    put(32'h1212, 32'h0000_0001, K_SEQ,  0);
    put(32'h1214, MRET_INSTR,   K_JUMP, 0);
    put(32'h121C, MRET_INSTR,   K_JUMP, 0);
    // five nested jal x1 and their returns, one more than the stack holds
    for (int i = 0; i < 5; i++) begin
      put(32'h1300 + 16 * i, 32'h0100_00EF, K_CALL, 16);
      put(32'h1304 + 16 * i, 32'h0000_8067, K_RET,  0);
    end
    put(32'h1350, 32'h0000_8067, K_RET,  0);
    put(32'h1318, MRET_INSTR,   K_JUMP, 0);
  endtask

  // ------------------------------
  // reference model and checks
  // ------------------------------
  task automatic check_entry();
    image_t e;
    logic   comp;
    logic   exp_taken;
    logic   redirect;
    vaddr_t seq;
    vaddr_t exp_target;
    logic [3:0] idx;
    redirect = resolve_i.valid && resolve_i.mispredict;
    if (!rst_n_i) begin
      assert (!entry_o.valid) else count_failure("entry_o.valid high during reset");
    end else begin
      e = read_image(model_pc);
      comp = (e.instr[1:0] != 2'b11);
      seq = model_pc + (comp ? 32'd2 : 32'd4);
      exp_taken = 1'b0;
      exp_target = seq;
      case (e.kind)
        K_BRANCH: begin
          if (cnt_m[model_pc[4:1]][1]) begin
            exp_taken = 1'b1;
            exp_target = model_pc + e.imm;
          end
        end
        K_JUMP, K_CALL: begin
          exp_taken = 1'b1;
          exp_target = model_pc + e.imm;
        end
        K_RET: begin
          if (ras_m.size() > 0) begin
            exp_taken = 1'b1;
            exp_target = ras_m[0];
          end
        end
        default: begin
        end
      endcase
      // the address must hold whenever nothing issues
      assert (fetch_addr_o == model_pc)
        else count_mismatch("fetch_addr_o", fetch_addr_o, model_pc);
      if (entry_o.valid) begin
        assert (!redirect) else count_failure("entry issued in a redirect cycle");
        assert (outstanding < DECODE_CREDITS)
          else count_failure("entry issued with no decode credit left");
        assert (entry_o.pc == model_pc) else count_mismatch("entry_o.pc", entry_o.pc, model_pc);
        assert (entry_o.instr == e.instr)
          else count_mismatch("entry_o.instr", entry_o.instr, e.instr);
        assert (entry_o.is_compressed == comp)
          else count_mismatch("entry_o.is_compressed", 32'(entry_o.is_compressed), 32'(comp));
        assert (entry_o.predict_taken == exp_taken)
          else count_mismatch("entry_o.predict_taken", 32'(entry_o.predict_taken),
                              32'(exp_taken));
        assert (entry_o.predict_target == exp_target)
          else count_mismatch("entry_o.predict_target", entry_o.predict_target, exp_target);
        issued++;
        outstanding++;
        model_pc = exp_target;
        if (e.kind == K_CALL) begin
          ras_m.push_front(seq);
          if (ras_m.size() > RAS_DEPTH) begin
            void'(ras_m.pop_back());
          end
        end else if (e.kind == K_RET && exp_taken) begin
          void'(ras_m.pop_front());
        end
      end
      if (redirect) begin
        model_pc = resolve_i.target;
      end
      // counters saturate at both ends
      if (resolve_i.valid && resolve_i.is_branch) begin
        idx = resolve_i.pc[4:1];
        if (resolve_i.taken && cnt_m[idx] != 2'b11) begin
          cnt_m[idx] = cnt_m[idx] + 2'd1;
        end else if (!resolve_i.taken && cnt_m[idx] != 2'b00) begin
          cnt_m[idx] = cnt_m[idx] - 2'd1;
        end
      end
      if (credit_i) begin
        outstanding--;
      end
    end
  endtask

  // check in the middle of the cycle, then drive just after the edge
  task automatic next_cycle();
    @(negedge clk_i);
    check_entry();
    @(posedge clk_i);
    #DRIVE_DELAY;
    resolve_i = '0;
    rng = xorshift(rng);
    credit_i = (outstanding > 0) && rng[0];
  endtask

  task automatic send_resolve(input logic is_branch, input vaddr_t pc, input logic taken,
                              input logic mispredict, input vaddr_t target);
    resolve_i.valid      = 1'b1;
    resolve_i.is_branch  = is_branch;
    resolve_i.pc         = pc;
    resolve_i.taken      = taken;
    resolve_i.mispredict = mispredict;
    resolve_i.target     = target;
    next_cycle();
  endtask

  // run until fetch parks on the given halt, then let it spin there
  task automatic run_until(input vaddr_t addr);
    while (model_pc != addr) begin
      next_cycle();
    end
    repeat (6) next_cycle();
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    credit_i = 1'b0;
    resolve_i = '0;
    model_pc = BOOT_ADDR;
    outstanding = 0;
    issued = 0;
    errors = 0;
    cycles = 0;
    rng = 32'h79a6;
    for (int i = 0; i < BHT_ENTRIES; i++) begin
      cnt_m[i] = BHT_WEAK_NT;
    end
    load_program();
    repeat (10) next_cycle();
    rst_n_i = 1'b1;

    run_until(32'h1040);
    // beq starts not-taken, one taken resolve flips it, two not-taken resolves restore it
    send_resolve(1'b0, '0, 1'b0, 1'b1, 32'h1100);
    run_until(32'h1104);
    send_resolve(1'b1, 32'h1100, 1'b1, 1'b1, 32'h1100);
    run_until(32'h110C);
    send_resolve(1'b1, 32'h1100, 1'b0, 1'b0, '0);
    send_resolve(1'b1, 32'h1100, 1'b0, 1'b1, 32'h1100);
    run_until(32'h1104);
    // same training on the compressed branch
    send_resolve(1'b0, '0, 1'b0, 1'b1, 32'h1210);
    run_until(32'h1214);
    send_resolve(1'b1, 32'h1210, 1'b1, 1'b1, 32'h1210);
    run_until(32'h121C);
    send_resolve(1'b1, 32'h1210, 1'b0, 1'b0, '0);
    send_resolve(1'b1, 32'h1210, 1'b0, 1'b1, 32'h1210);
    run_until(32'h1214);
    // stack overflow by nested calls
    send_resolve(1'b0, '0, 1'b0, 1'b1, 32'h1300);
    run_until(32'h1318);

    $display("run done after %0d cycles: %0d entries checked, %0d errors",
             cycles, issued, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== frontend.f ====
hdl/fetch_pkg.sv
hdl/instr_scan.sv
hdl/bht.sv
hdl/ras.sv
hdl/frontend.sv
testbench/tb_frontend.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

TOP = tb_frontend

all: run

obj_dir/sim: frontend.f hdl/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f frontend.f --top-module $(TOP) -o sim

# passes only when the testbench prints the pass line
run: obj_dir/sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing -f frontend.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
